/* logic/wadj_pkg.sv */
// supports only the 128-to-32 ratio; ingress keep must be whole nibbles and never all zero
package wadj_pkg;

   // ------------------------------------------------------------
   // datapath widths
   // ------------------------------------------------------------

   // ingress beat, byte 0 in bits 7:0
   localparam int igr_data_w = 128;
   localparam int igr_keep_w = 16;

   // egress segment
   localparam int egr_data_w = 32;
   localparam int egr_keep_w = 4;

   // segments carved out of one ingress beat
   localparam int num_seg = 4;

   // sideband fields, repeated on every segment of a beat
   localparam int md_w = 8;
   localparam int port_w = 4;
   localparam int mcast_port_w = 16;

   // ------------------------------------------------------------
   // register port
   // ------------------------------------------------------------

   localparam int csr_addr_w = 4;
   localparam int csr_data_w = 32;

   // word addresses, anything else reads back as zero
   typedef enum logic [csr_addr_w-1:0] {
      csr_ctrl      = 4'd0,
      csr_pkt_count = 4'd4
   } csr_addr_e;

   // ------------------------------------------------------------
   // splitter FSM
   // ------------------------------------------------------------

   // idle means the beat register is empty and ingress is open
   typedef enum logic {
      split_idle = 1'b0,
      split_busy = 1'b1
   } split_state_e;

endpackage

/* logic/wadj_csr.sv */
// no byte enables; a count write clears regardless of data and drops a same-cycle packet
`timescale 1ns/1ps

module wadj_csr (
   input  logic                             clk,
   input  logic                             rst_reg_posedge,

   input  logic [wadj_pkg::csr_addr_w-1:0]  csr_addr_i,
   input  logic                             csr_read_i,
   input  logic                             csr_write_i,
   input  logic [wadj_pkg::csr_data_w-1:0]  csr_wdata_i,

   // one pulse per egress packet
   input  logic                             pkt_done_i,

   output logic [wadj_pkg::csr_data_w-1:0]  csr_rdata_o,
   output logic                             csr_rvalid_o,
   output logic                             rotate_en_o
);

   wadj_pkg::csr_addr_e                 addr;
   logic                                rotate_en_q;
   logic [wadj_pkg::csr_data_w-1:0]     pkt_count_q;
   logic [wadj_pkg::csr_data_w-1:0]     rdata_next;
   logic                                wr_ctrl;
   logic                                wr_count;

   // ------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------

   assign addr     = wadj_pkg::csr_addr_e'(csr_addr_i);
   assign wr_ctrl  = csr_write_i && (addr == wadj_pkg::csr_ctrl);
   assign wr_count = csr_write_i && (addr == wadj_pkg::csr_pkt_count);

   // ------------------------------------------------------------
   // control and counter
   // ------------------------------------------------------------

   // rotation defaults on
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         rotate_en_q <= 1'b1;
      end else if (wr_ctrl) begin
         rotate_en_q <= csr_wdata_i[0];
      end
   end

   // write-to-clear wins over a packet finishing on the same edge
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         pkt_count_q <= '0;
      end else if (wr_count) begin
         pkt_count_q <= '0;
      end else if (pkt_done_i) begin
         pkt_count_q <= pkt_count_q + 1'b1;
      end
   end

   assign rotate_en_o = rotate_en_q;

   // ------------------------------------------------------------
   // read path
   // ------------------------------------------------------------

   always_comb begin
      case (addr)
         wadj_pkg::csr_ctrl: begin
            rdata_next = {{(wadj_pkg::csr_data_w-1){1'b0}}, rotate_en_q};
         end
         wadj_pkg::csr_pkt_count: begin
            rdata_next = pkt_count_q;
         end
         default: begin
            rdata_next = '0;
         end
      endcase
   end

   // data lands with rvalid one edge after the read
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= csr_read_i;
      end
   end

   always_ff @(posedge clk) begin
      if (csr_read_i) begin
         csr_rdata_o <= rdata_next;
      end
   end

endmodule

/* logic/wadj_splitter.sv */
// holds one beat at a time; ingress keep must be whole nibbles with at least one set
`timescale 1ns/1ps

module wadj_splitter (
   input  logic                               clk,
   input  logic                               rst_reg_posedge,
   input  logic                               rotate_en_i,

   // ingress beat
   input  logic                               s_valid_i,
   output logic                               s_ready_o,
   input  logic [wadj_pkg::igr_data_w-1:0]    s_data_i,
   input  logic [wadj_pkg::igr_keep_w-1:0]    s_keep_i,
   input  logic                               s_eop_i,
   input  logic [wadj_pkg::md_w-1:0]          s_md_i,
   input  logic [wadj_pkg::port_w-1:0]        s_igr_port_i,
   input  logic [wadj_pkg::port_w-1:0]        s_egr_port_i,
   input  logic [wadj_pkg::mcast_port_w-1:0]  s_mcast_port_i,
   input  logic                               s_mcast_en_i,

   input  logic                               m_ready_i,

   // one segment per cycle toward the framer
   output logic                               seg_valid_o,
   output logic [wadj_pkg::egr_data_w-1:0]    seg_data_o,
   output logic [wadj_pkg::egr_keep_w-1:0]    seg_keep_o,
   output logic                               seg_last_o,
   output logic [wadj_pkg::md_w-1:0]          seg_md_o,
   output logic [wadj_pkg::port_w-1:0]        seg_igr_port_o,
   output logic [wadj_pkg::port_w-1:0]        seg_egr_port_o,
   output logic [wadj_pkg::mcast_port_w-1:0]  seg_mcast_port_o,
   output logic                               seg_mcast_en_o
);

   wadj_pkg::split_state_e                  state_q;
   logic [wadj_pkg::num_seg-1:0]            pending_q;

   // stored beat
   logic [wadj_pkg::igr_data_w-1:0]         data_q;
   logic [wadj_pkg::igr_keep_w-1:0]         keep_q;
   logic                                    eop_q;
   logic [wadj_pkg::md_w-1:0]               md_q;
   logic [wadj_pkg::port_w-1:0]             igr_port_q;
   logic [wadj_pkg::port_w-1:0]             egr_port_q;
   logic [wadj_pkg::mcast_port_w-1:0]       mcast_port_q;
   logic                                    mcast_en_q;

   logic [wadj_pkg::igr_data_w-1:0]         data_in;
   logic [wadj_pkg::igr_keep_w-1:0]         keep_in;
   logic [wadj_pkg::num_seg-1:0]            nonempty_in;
   logic [$clog2(wadj_pkg::num_seg)-1:0]    cur_idx;
   logic [wadj_pkg::num_seg-1:0]            cur_mask;
   logic [wadj_pkg::num_seg-1:0]            rest_mask;
   logic                                    accept;
   logic                                    advance;

   // byte 15 moves to byte 0
   function automatic logic [wadj_pkg::igr_data_w-1:0] reverse_bytes(
      input logic [wadj_pkg::igr_data_w-1:0] din);
      logic [wadj_pkg::igr_data_w-1:0] dout;
      for (int i = 0; i < wadj_pkg::igr_keep_w; i++) begin
         dout[i*8 +: 8] = din[(wadj_pkg::igr_keep_w-1-i)*8 +: 8];
      end
      return dout;
   endfunction

   // keep bits follow their bytes
   function automatic logic [wadj_pkg::igr_keep_w-1:0] reverse_keep(
      input logic [wadj_pkg::igr_keep_w-1:0] kin);
      logic [wadj_pkg::igr_keep_w-1:0] kout;
      for (int i = 0; i < wadj_pkg::igr_keep_w; i++) begin
         kout[i] = kin[wadj_pkg::igr_keep_w-1-i];
      end
      return kout;
   endfunction

   // ------------------------------------------------------------
   // ingress side
   // ------------------------------------------------------------

   assign s_ready_o = (state_q == wadj_pkg::split_idle);
   assign accept    = s_valid_i && s_ready_o;
   assign data_in   = rotate_en_i ? reverse_bytes(s_data_i) : s_data_i;
   assign keep_in   = rotate_en_i ? reverse_keep(s_keep_i) : s_keep_i;

   always_comb begin
      for (int i = 0; i < wadj_pkg::num_seg; i++) begin
         nonempty_in[i] = |keep_in[i*wadj_pkg::egr_keep_w +: wadj_pkg::egr_keep_w];
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q       <= data_in;
         keep_q       <= keep_in;
         eop_q        <= s_eop_i;
         md_q         <= s_md_i;
         igr_port_q   <= s_igr_port_i;
         egr_port_q   <= s_egr_port_i;
         mcast_port_q <= s_mcast_port_i;
         mcast_en_q   <= s_mcast_en_i;
      end
   end

   // ------------------------------------------------------------
   // segment select, lowest pending index first
   // ------------------------------------------------------------

   always_comb begin
      cur_idx = '0;
      for (int i = wadj_pkg::num_seg-1; i >= 0; i--) begin
         if (pending_q[i]) begin
            cur_idx = i[$clog2(wadj_pkg::num_seg)-1:0];
         end
      end
      cur_mask          = '0;
      cur_mask[cur_idx] = 1'b1;
      rest_mask         = pending_q & ~cur_mask;
   end

   assign advance = seg_valid_o && m_ready_i;

   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         state_q   <= wadj_pkg::split_idle;
         pending_q <= '0;
      end else begin
         case (state_q)
            wadj_pkg::split_idle: begin
               if (accept) begin
                  state_q   <= wadj_pkg::split_busy;
                  pending_q <= nonempty_in;
               end
            end
            wadj_pkg::split_busy: begin
               if (advance) begin
                  pending_q <= rest_mask;
                  // beat drained, reopen ingress next cycle
                  if (rest_mask == '0) begin
                     state_q <= wadj_pkg::split_idle;
                  end
               end
            end
            default: begin
               state_q <= wadj_pkg::split_idle;
            end
         endcase
      end
   end

   // ------------------------------------------------------------
   // segment outputs
   // ------------------------------------------------------------

   assign seg_valid_o      = (state_q == wadj_pkg::split_busy);
   assign seg_data_o       = data_q[cur_idx*wadj_pkg::egr_data_w +: wadj_pkg::egr_data_w];
   assign seg_keep_o       = keep_q[cur_idx*wadj_pkg::egr_keep_w +: wadj_pkg::egr_keep_w];
   assign seg_last_o       = eop_q && (rest_mask == '0);
   assign seg_md_o         = md_q;
   assign seg_igr_port_o   = igr_port_q;
   assign seg_egr_port_o   = egr_port_q;
   assign seg_mcast_port_o = mcast_port_q;
   assign seg_mcast_en_o   = mcast_en_q;

endmodule

/* logic/wadj_framer.sv */
// zero-latency pass-through; multicast fields of later segments come from the packet's first one
`timescale 1ns/1ps

module wadj_framer (
   input  logic                               clk,
   input  logic                               rst_reg_posedge,

   input  logic                               seg_valid_i,
   input  logic [wadj_pkg::egr_data_w-1:0]    seg_data_i,
   input  logic [wadj_pkg::egr_keep_w-1:0]    seg_keep_i,
   input  logic                               seg_last_i,
   input  logic [wadj_pkg::md_w-1:0]          seg_md_i,
   input  logic [wadj_pkg::port_w-1:0]        seg_igr_port_i,
   input  logic [wadj_pkg::port_w-1:0]        seg_egr_port_i,
   input  logic [wadj_pkg::mcast_port_w-1:0]  seg_mcast_port_i,
   input  logic                               seg_mcast_en_i,

   input  logic                               m_ready_i,

   output logic                               m_valid_o,
   output logic [wadj_pkg::egr_data_w-1:0]    m_data_o,
   output logic [wadj_pkg::egr_keep_w-1:0]    m_keep_o,
   output logic                               m_last_o,
   output logic                               m_last_segment_o,
   output logic                               m_sop_o,
   output logic [wadj_pkg::md_w-1:0]          m_md_o,
   output logic [wadj_pkg::port_w-1:0]        m_igr_port_o,
   output logic [wadj_pkg::port_w-1:0]        m_egr_port_o,
   output logic [wadj_pkg::mcast_port_w-1:0]  m_mcast_port_o,
   output logic                               m_mcast_en_o,

   output logic                               pkt_done_o
);

   logic                                sop_q;
   logic [wadj_pkg::mcast_port_w-1:0]   mcast_port_q;
   logic                                mcast_en_q;
   logic                                xfer;

   assign xfer = seg_valid_i && m_ready_i;

   // ------------------------------------------------------------
   // start-of-packet tracking
   // ------------------------------------------------------------

   // set after a last segment, cleared after any other
   always_ff @(posedge clk) begin
      if (rst_reg_posedge) begin
         sop_q <= 1'b1;
      end else if (xfer) begin
         sop_q <= seg_last_i;
      end
   end

   // first segment's multicast fields, held for the packet
   always_ff @(posedge clk) begin
      if (sop_q && seg_valid_i) begin
         mcast_port_q <= seg_mcast_port_i;
         mcast_en_q   <= seg_mcast_en_i;
      end
   end

   // ------------------------------------------------------------
   // egress fields
   // ------------------------------------------------------------

   assign m_valid_o        = seg_valid_i;
   assign m_data_o         = seg_data_i;
   assign m_keep_o         = seg_keep_i;
   assign m_last_o         = seg_last_i;
   assign m_last_segment_o = seg_last_i;
   assign m_sop_o          = sop_q;
   assign m_md_o           = seg_md_i;
   assign m_igr_port_o     = seg_igr_port_i;
   assign m_egr_port_o     = seg_egr_port_i;
   assign m_mcast_port_o   = sop_q ? seg_mcast_port_i : mcast_port_q;
   assign m_mcast_en_o     = sop_q ? seg_mcast_en_i : mcast_en_q;

   // counted by the register block
   assign pkt_done_o = xfer && seg_last_i;

endmodule

/* logic/wadj_top.sv */
// one beat in flight at a time, so ingress throughput is bounded by the egress segment count
`timescale 1ns/1ps

module wadj_top (
   input  logic                               clk,
   input  logic                               rst_reg_posedge,

   // ingress stream
   input  logic                               s_valid_i,
   output logic                               s_ready_o,
   input  logic [wadj_pkg::igr_data_w-1:0]    s_data_i,
   input  logic [wadj_pkg::igr_keep_w-1:0]    s_keep_i,
   input  logic                               s_eop_i,
   input  logic [wadj_pkg::md_w-1:0]          s_md_i,
   input  logic [wadj_pkg::port_w-1:0]        s_igr_port_i,
   input  logic [wadj_pkg::port_w-1:0]        s_egr_port_i,
   input  logic [wadj_pkg::mcast_port_w-1:0]  s_mcast_port_i,
   input  logic                               s_mcast_en_i,

   // egress stream
   output logic                               m_valid_o,
   input  logic                               m_ready_i,
   output logic [wadj_pkg::egr_data_w-1:0]    m_data_o,
   output logic [wadj_pkg::egr_keep_w-1:0]    m_keep_o,
   output logic                               m_last_o,
   output logic                               m_last_segment_o,
   output logic                               m_sop_o,
   output logic [wadj_pkg::md_w-1:0]          m_md_o,
   output logic [wadj_pkg::port_w-1:0]        m_igr_port_o,
   output logic [wadj_pkg::port_w-1:0]        m_egr_port_o,
   output logic [wadj_pkg::mcast_port_w-1:0]  m_mcast_port_o,
   output logic                               m_mcast_en_o,

   // register port
   input  logic [wadj_pkg::csr_addr_w-1:0]    csr_addr_i,
   input  logic                               csr_read_i,
   input  logic                               csr_write_i,
   input  logic [wadj_pkg::csr_data_w-1:0]    csr_wdata_i,
   output logic [wadj_pkg::csr_data_w-1:0]    csr_rdata_o,
   output logic                               csr_rvalid_o
);

   logic                              rotate_en;
   logic                              pkt_done;

   // splitter to framer
   logic                              seg_valid;
   logic [wadj_pkg::egr_data_w-1:0]   seg_data;
   logic [wadj_pkg::egr_keep_w-1:0]   seg_keep;
   logic                              seg_last;
   logic [wadj_pkg::md_w-1:0]         seg_md;
   logic [wadj_pkg::port_w-1:0]       seg_igr_port;
   logic [wadj_pkg::port_w-1:0]       seg_egr_port;
   logic [wadj_pkg::mcast_port_w-1:0] seg_mcast_port;
   logic                              seg_mcast_en;

   wadj_csr csr0 (
      .clk (clk), .rst_reg_posedge (rst_reg_posedge),
      .csr_addr_i (csr_addr_i), .csr_read_i (csr_read_i),
      .csr_write_i (csr_write_i), .csr_wdata_i (csr_wdata_i),
      .pkt_done_i (pkt_done),
      .csr_rdata_o (csr_rdata_o), .csr_rvalid_o (csr_rvalid_o),
      .rotate_en_o (rotate_en)
   );

   wadj_splitter split0 (
      .clk (clk), .rst_reg_posedge (rst_reg_posedge), .rotate_en_i (rotate_en),
      .s_valid_i (s_valid_i), .s_ready_o (s_ready_o),
      .s_data_i (s_data_i), .s_keep_i (s_keep_i), .s_eop_i (s_eop_i),
      .s_md_i (s_md_i), .s_igr_port_i (s_igr_port_i), .s_egr_port_i (s_egr_port_i),
      .s_mcast_port_i (s_mcast_port_i), .s_mcast_en_i (s_mcast_en_i),
      .m_ready_i (m_ready_i),
      .seg_valid_o (seg_valid), .seg_data_o (seg_data), .seg_keep_o (seg_keep),
      .seg_last_o (seg_last), .seg_md_o (seg_md),
      .seg_igr_port_o (seg_igr_port), .seg_egr_port_o (seg_egr_port),
      .seg_mcast_port_o (seg_mcast_port), .seg_mcast_en_o (seg_mcast_en)
   );

   wadj_framer frame0 (
      .clk (clk), .rst_reg_posedge (rst_reg_posedge),
      .seg_valid_i (seg_valid), .seg_data_i (seg_data), .seg_keep_i (seg_keep),
      .seg_last_i (seg_last), .seg_md_i (seg_md),
      .seg_igr_port_i (seg_igr_port), .seg_egr_port_i (seg_egr_port),
      .seg_mcast_port_i (seg_mcast_port), .seg_mcast_en_i (seg_mcast_en),
      .m_ready_i (m_ready_i),
      .m_valid_o (m_valid_o), .m_data_o (m_data_o), .m_keep_o (m_keep_o),
      .m_last_o (m_last_o), .m_last_segment_o (m_last_segment_o),
      .m_sop_o (m_sop_o), .m_md_o (m_md_o),
      .m_igr_port_o (m_igr_port_o), .m_egr_port_o (m_egr_port_o),
      .m_mcast_port_o (m_mcast_port_o), .m_mcast_en_o (m_mcast_en_o),
      .pkt_done_o (pkt_done)
   );

endmodule

/* test/wadj_clk_gen.sv */
// free-running 40 ns clock; reset is held high for the first five rising edges
`timescale 1ns/1ps

module wadj_clk_gen (
   output logic clk,
   output logic rst_reg_posedge
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // release on an edge so the DUT sees a clean synchronous deassert
   initial begin
      rst_reg_posedge = 1'b1;
      repeat (5) @(posedge clk);
      rst_reg_posedge <= 1'b0;
   end

endmodule

/* test/wadj_assertions.sv */
// protocol checks on the top level; csr reads are assumed never to be issued back to back
`timescale 1ns/1ps

module wadj_assertions (
   input logic                            clk,
   input logic                            rst_reg_posedge,
   input logic                            m_valid_i,
   input logic                            m_ready_i,
   input logic [wadj_pkg::egr_data_w-1:0] m_data_i,
   input logic                            s_ready_i,
   input logic                            csr_rvalid_i
);

   // failed assertions so far
   int fail_count = 0;

   // a stalled segment must hold until taken
   assert property (@(posedge clk) disable iff (rst_reg_posedge)
      (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_data_i)))
      else begin
         $error("egress segment dropped or changed while stalled");
         fail_count++;
      end

   // only one beat in flight
   assert property (@(posedge clk) disable iff (rst_reg_posedge)
      m_valid_i |-> !s_ready_i)
      else begin
         $error("ingress ready while a segment is pending");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (rst_reg_posedge)
      csr_rvalid_i |=> !csr_rvalid_i)
      else begin
         $error("read valid held longer than one cycle");
         fail_count++;
      end

endmodule

bind wadj_top wadj_assertions asrt0 (
   .clk             (clk),
   .rst_reg_posedge (rst_reg_posedge),
   .m_valid_i       (m_valid_o),
   .m_ready_i       (m_ready_i),
   .m_data_i        (m_data_o),
   .s_ready_i       (s_ready_o),
   .csr_rvalid_i    (csr_rvalid_o)
);

/* test/wadj_tb.sv */
// every table row ends its last beat with eop, so each row is exactly one egress packet
`timescale 1ns/1ps

module wadj_tb;

   localparam int num_rows  = 5;
   localparam int max_beats = 3;

   logic         clk;
   logic         rst_reg_posedge;

   logic         s_valid_i;
   logic         s_ready_o;
   logic [127:0] s_data_i;
   logic [15:0]  s_keep_i;
   logic         s_eop_i;
   logic [7:0]   s_md_i;
   logic [3:0]   s_igr_port_i;
   logic [3:0]   s_egr_port_i;
   logic [15:0]  s_mcast_port_i;
   logic         s_mcast_en_i;
   logic         m_valid_o;
   logic         m_ready_i;
   logic [31:0]  m_data_o;
   logic [3:0]   m_keep_o;
   logic         m_last_o;
   logic         m_last_segment_o;
   logic         m_sop_o;
   logic [7:0]   m_md_o;
   logic [3:0]   m_igr_port_o;
   logic [3:0]   m_egr_port_o;
   logic [15:0]  m_mcast_port_o;
   logic         m_mcast_en_o;
   logic [3:0]   csr_addr_i;
   logic         csr_read_i;
   logic         csr_write_i;
   logic [31:0]  csr_wdata_i;
   logic [31:0]  csr_rdata_o;
   logic         csr_rvalid_o;

   // ------------------------------------------------------------
   // stimulus table
   // ------------------------------------------------------------

   string        row_name  [num_rows];
   bit           row_rot   [num_rows];
   bit           row_bp    [num_rows];
   int           row_beats [num_rows];
   logic [127:0] beat_data [num_rows][max_beats];
   logic [15:0]  beat_keep [num_rows][max_beats];
   bit           beat_eop  [num_rows][max_beats];
   logic [7:0]   beat_md   [num_rows][max_beats];
   logic [3:0]   beat_igr  [num_rows][max_beats];
   logic [3:0]   beat_egr  [num_rows][max_beats];
   logic [15:0]  beat_mcp  [num_rows][max_beats];
   bit           beat_mce  [num_rows][max_beats];

   // expected egress segments, oldest first
   string       exp_name [$];
   logic [31:0] exp_data [$];
   logic [3:0]  exp_keep [$];
   bit          exp_last [$];
   bit          exp_sop  [$];
   logic [7:0]  exp_md   [$];
   logic [3:0]  exp_igr  [$];
   logic [3:0]  exp_egr  [$];
   logic [15:0] exp_mcp  [$];
   bit          exp_mce  [$];

   bit          model_sop = 1'b1;
   logic [15:0] hold_mcp;
   bit          hold_mce;

   int          value_errs  = 0;
   int          other_errs  = 0;
   int          cycles      = 0;
   int          cycle_limit = 1000;
   bit          bp_active   = 1'b0;
   logic [31:0] rng         = 32'h222b;
   logic [31:0] rd;

   wadj_clk_gen clkgen0 (.clk (clk), .rst_reg_posedge (rst_reg_posedge));

   wadj_top dut0 (.*);

   task automatic set_beat(input int r, input int b, input logic [127:0] d,
                           input logic [15:0] k, input bit eop, input logic [7:0] md,
                           input logic [3:0] igr, input logic [3:0] egr,
                           input logic [15:0] mcp, input bit mce);
      beat_data[r][b] = d;
      beat_keep[r][b] = k;
      beat_eop[r][b]  = eop;
      beat_md[r][b]   = md;
      beat_igr[r][b]  = igr;
      beat_egr[r][b]  = egr;
      beat_mcp[r][b]  = mcp;
      beat_mce[r][b]  = mce;
   endtask

   task automatic load_table();
      row_name = '{"full_beat_plain", "full_beat_reversed", "sparse_keep",
                   "multicast_hold", "random_ready"};
      row_rot   = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
      row_bp    = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
      row_beats = '{1, 1, 1, 3, 3};
      set_beat(0, 0, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 16'hffff, 1'b1,
               8'h11, 4'h1, 4'h2, 16'h00a5, 1'b1);
      set_beat(1, 0, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 16'hffff, 1'b1,
               8'h22, 4'h3, 4'h4, 16'h0f0f, 1'b0);
      set_beat(2, 0, 128'hdeadbeef_cafef00d_01234567_89abcdef, 16'h0f0f, 1'b1,
               8'h33, 4'h5, 4'h6, 16'h1234, 1'b1);
      // later beats carry other multicast fields that must not show
      set_beat(3, 0, 128'h10111213_14151617_18191a1b_1c1d1e1f, 16'hffff, 1'b0,
               8'h41, 4'h7, 4'h8, 16'hbeef, 1'b1);
      set_beat(3, 1, 128'h20212223_24252627_28292a2b_2c2d2e2f, 16'hffff, 1'b0,
               8'h42, 4'h9, 4'ha, 16'h1111, 1'b0);
      set_beat(3, 2, 128'h30313233_34353637_38393a3b_3c3d3e3f, 16'h00ff, 1'b1,
               8'h43, 4'hb, 4'hc, 16'h2222, 1'b0);
      set_beat(4, 0, 128'ha0a1a2a3_a4a5a6a7_a8a9aaab_acadaeaf, 16'hffff, 1'b0,
               8'h51, 4'hd, 4'he, 16'h5a5a, 1'b0);
      set_beat(4, 1, 128'hb0b1b2b3_b4b5b6b7_b8b9babb_bcbdbebf, 16'hf0f0, 1'b0,
               8'h52, 4'hf, 4'h0, 16'h6b6b, 1'b1);
      set_beat(4, 2, 128'hc0c1c2c3_c4c5c6c7_c8c9cacb_cccdcecf, 16'hfff0, 1'b1,
               8'h53, 4'h1, 4'h3, 16'h7c7c, 1'b1);
   endtask

   function automatic logic [31:0] next_random(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------

   // output byte i comes from input byte 15-i when reversed
   task automatic model_beat(input int r, input int b);
      logic [7:0]  bytes_out [16];
      logic [15:0] keep_out;
      int          src;
      int          last_seg;
      bit          is_last;
      for (int i = 0; i < 16; i++) begin
         src          = row_rot[r] ? 15 - i : i;
         bytes_out[i] = beat_data[r][b][src*8 +: 8];
         keep_out[i]  = beat_keep[r][b][src];
      end
      last_seg = -1;
      for (int s = 0; s < wadj_pkg::num_seg; s++) begin
         if (keep_out[s*4 +: 4] != 4'h0) last_seg = s;
      end
      for (int s = 0; s < wadj_pkg::num_seg; s++) begin
         if (keep_out[s*4 +: 4] != 4'h0) begin
            is_last = beat_eop[r][b] && (s == last_seg);
            if (model_sop) begin
               hold_mcp = beat_mcp[r][b];
               hold_mce = beat_mce[r][b];
            end
            exp_name.push_back(row_name[r]);
            exp_data.push_back({bytes_out[s*4+3], bytes_out[s*4+2],
                                bytes_out[s*4+1], bytes_out[s*4]});
            exp_keep.push_back(keep_out[s*4 +: 4]);
            exp_last.push_back(is_last);
            exp_sop.push_back(model_sop);
            exp_md.push_back(beat_md[r][b]);
            exp_igr.push_back(beat_igr[r][b]);
            exp_egr.push_back(beat_egr[r][b]);
            exp_mcp.push_back(hold_mcp);
            exp_mce.push_back(hold_mce);
            model_sop = is_last;
         end
      end
   endtask

   task automatic check_value(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         value_errs++;
         $display("error %s %s: expected %h actual %h", test, field, exp, act);
      end
   endtask

   // ------------------------------------------------------------
   // drivers
   // ------------------------------------------------------------

   task automatic write_csr(input logic [3:0] addr, input logic [31:0] data);
      csr_addr_i  <= addr;
      csr_wdata_i <= data;
      csr_write_i <= 1'b1;
      @(posedge clk);
      csr_write_i <= 1'b0;
   endtask

   task automatic read_csr(input logic [3:0] addr, output logic [31:0] data);
      csr_addr_i <= addr;
      csr_read_i <= 1'b1;
      @(posedge clk);
      csr_read_i <= 1'b0;
      @(posedge clk);
      while (!csr_rvalid_o) @(posedge clk);
      data = csr_rdata_o;
   endtask

   task automatic run_row(input int r);
      bp_active <= row_bp[r];
      write_csr(wadj_pkg::csr_ctrl, {31'd0, row_rot[r]});
      for (int b = 0; b < row_beats[r]; b++) begin
         model_beat(r, b);
         s_valid_i      <= 1'b1;
         s_data_i       <= beat_data[r][b];
         s_keep_i       <= beat_keep[r][b];
         s_eop_i        <= beat_eop[r][b];
         s_md_i         <= beat_md[r][b];
         s_igr_port_i   <= beat_igr[r][b];
         s_egr_port_i   <= beat_egr[r][b];
         s_mcast_port_i <= beat_mcp[r][b];
         s_mcast_en_i   <= beat_mce[r][b];
         @(posedge clk);
         while (!s_ready_o) @(posedge clk);
      end
      s_valid_i <= 1'b0;
      while (exp_data.size() != 0) @(posedge clk);
      bp_active <= 1'b0;
   endtask

   always @(posedge clk) begin
      if (bp_active) begin
         rng = next_random(rng);
         m_ready_i <= rng[0];
      end else begin
         m_ready_i <= 1'b1;
      end
   end

   // ------------------------------------------------------------
   // egress monitor and timeout
   // ------------------------------------------------------------

   always @(posedge clk) begin : monitor
      string name;
      if (!rst_reg_posedge && m_valid_o && m_ready_i) begin
         assert (exp_data.size() > 0) else begin
            other_errs++;
            $display("egress segment arrived when none was expected");
         end
         if (exp_data.size() > 0) begin
            name = exp_name.pop_front();
            check_value(name, "data", exp_data.pop_front(), m_data_o);
            check_value(name, "keep", exp_keep.pop_front(), m_keep_o);
            check_value(name, "last", exp_last[0], m_last_o);
            check_value(name, "last_segment", exp_last.pop_front(), m_last_segment_o);
            check_value(name, "sop", exp_sop.pop_front(), m_sop_o);
            check_value(name, "md", exp_md.pop_front(), m_md_o);
            check_value(name, "igr_port", exp_igr.pop_front(), m_igr_port_o);
            check_value(name, "egr_port", exp_egr.pop_front(), m_egr_port_o);
            check_value(name, "mcast_port", exp_mcp.pop_front(), m_mcast_port_o);
            check_value(name, "mcast_en", exp_mce.pop_front(), m_mcast_en_o);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("value errors: %0d, other errors: %0d", value_errs, other_errs + 1);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------

   initial begin : main
      int segs;
      s_valid_i      = 1'b0;
      s_data_i       = '0;
      s_keep_i       = '0;
      s_eop_i        = 1'b0;
      s_md_i         = '0;
      s_igr_port_i   = '0;
      s_egr_port_i   = '0;
      s_mcast_port_i = '0;
      s_mcast_en_i   = 1'b0;
      m_ready_i      = 1'b1;
      csr_addr_i     = '0;
      csr_read_i     = 1'b0;
      csr_write_i    = 1'b0;
      csr_wdata_i    = '0;
      load_table();

      // eight cycles per egress segment, plus slack for reset and csr traffic
      segs = 0;
      for (int r = 0; r < num_rows; r++) begin
         for (int b = 0; b < row_beats[r]; b++) begin
            for (int s = 0; s < wadj_pkg::num_seg; s++) begin
               if (beat_keep[r][b][s*4 +: 4] != 4'h0) segs++;
            end
         end
      end
      cycle_limit = 8 * segs + 200;

      @(posedge clk);
      while (rst_reg_posedge) @(posedge clk);

      for (int r = 0; r < num_rows; r++) begin
         run_row(r);
         read_csr(wadj_pkg::csr_pkt_count, rd);
         check_value(row_name[r], "pkt_count", r + 1, rd);
      end
      // any write clears, whatever the data
      write_csr(wadj_pkg::csr_pkt_count, 32'h0000_00a5);
      read_csr(wadj_pkg::csr_pkt_count, rd);
      check_value("count_clear", "pkt_count", 32'h0, rd);

      assert (exp_data.size() == 0) else begin
         other_errs++;
         $display("%0d expected segments never appeared", exp_data.size());
      end

      // bound protocol checks keep their own count
      other_errs += dut0.asrt0.fail_count;

      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* all.f */
logic/wadj_pkg.sv
logic/wadj_csr.sv
logic/wadj_splitter.sv
logic/wadj_framer.sv
logic/wadj_top.sv
test/wadj_clk_gen.sv
test/wadj_assertions.sv
test/wadj_tb.sv
